//--- verilog/hc_pkg.sv
// line, buffer id, length and request/command struct types of the buffer copy engine.
package hc_pkg;

  localparam int LINE_BITS   = 64;
  localparam int NUM_BUFFERS = 2;
  localparam int MAX_LINES   = 64;

  typedef logic [LINE_BITS-1:0]           t_buffer_data;
  typedef logic [$clog2(NUM_BUFFERS)-1:0] t_buffer_id;
  typedef logic [$clog2(MAX_LINES)-1:0]   t_line_addr;
  typedef logic [$clog2(MAX_LINES):0]     t_request_size; // one extra bit so a full buffer fits.

  typedef struct packed {
    t_buffer_id    src;
    t_buffer_id    dst;
    t_request_size length;
  } t_copy_req;

  typedef struct packed {
    logic          strobe;
    t_buffer_id    id;
    t_request_size length;
  } t_read_cmd;

  typedef struct packed {
    logic         valid;
    t_buffer_data data;
  } t_read_rsp;

  typedef struct packed {
    logic         valid;
    t_buffer_id   id;
    t_line_addr   addr;
    t_buffer_data data;
  } t_write_req;

  typedef struct packed {
    logic         valid;
    logic         write;
    t_buffer_id   id;
    t_line_addr   addr;
    t_buffer_data data;
  } t_host_req;

  typedef struct packed {
    logic         valid;
    t_buffer_data data;
  } t_host_rsp;

endpackage : hc_pkg

//--- verilog/loopback_fifo.sv
// synchronous circular FIFO with a type-parameter payload, full/empty flags and occupancy count.
`timescale 1ns/1ps

module loopback_fifo #(
  parameter int  DEPTH  = 8,
  parameter type T_DATA = hc_pkg::t_buffer_data
) (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  enq_en,
  input  T_DATA                 enq_data,
  output logic                  not_full,
  input  logic                  deq_en,
  output T_DATA                 deq_data,
  output logic                  not_empty,
  output hc_pkg::t_request_size counter
);
  import hc_pkg::*;

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(DEPTH - 1);

  T_DATA            mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic             do_enq;
  logic             do_deq;

  function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
    return (ptr == LAST_PTR) ? '0 : ptr + 1'b1; // wraps for any depth.
  endfunction

  assign not_full  = (counter != t_request_size'(DEPTH));
  assign not_empty = (counter != '0);
  assign do_enq    = enq_en && not_full;
  assign do_deq    = deq_en && not_empty;
  assign deq_data  = mem[rd_ptr]; // head entry is visible before the dequeue.

  always_ff @(posedge clk) begin
    if (do_enq) begin
      mem[wr_ptr] <= enq_data;
    end
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      counter <= '0;
    end else begin
      if (do_enq) begin
        wr_ptr <= next_ptr(wr_ptr);
      end
      if (do_deq) begin
        rd_ptr <= next_ptr(rd_ptr);
      end
      case ({do_enq, do_deq})
        2'b10:   counter <= counter + t_request_size'(1);
        2'b01:   counter <= counter - t_request_size'(1);
        default: counter <= counter;
      endcase
    end
  end

endmodule : loopback_fifo

//--- verilog/loopback.sv
// copy engine with read command, read capture, FIFO drain, line write and finish logic.
`timescale 1ns/1ps

module loopback #(
  parameter int FIFO_DEPTH = 8
) (
  input  logic               clk,
  input  logic               reset,
  input  logic               start,
  input  hc_pkg::t_copy_req  copy_req,
  output logic               busy,
  output logic               finish,
  output hc_pkg::t_read_cmd  read_cmd,
  output logic               read_hold,
  input  hc_pkg::t_read_rsp  read_rsp,
  output hc_pkg::t_write_req write_req,
  input  logic               write_full
);
  import hc_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_REQUEST,
    S_STREAM
  } t_state;

  // a read may be issued while two earlier lines are still on their way to the FIFO.
  localparam t_request_size HOLD_LEVEL = t_request_size'(FIFO_DEPTH - 2);

  t_state        state;
  t_copy_req     req_q;
  logic          fifo_enq_en;
  t_buffer_data  fifo_enq_data;
  logic          fifo_not_full;
  logic          fifo_deq_en;
  t_buffer_data  fifo_deq_data;
  logic          fifo_not_empty;
  t_request_size fifo_counter;
  logic          out_valid;
  t_buffer_data  out_data;
  t_request_size wr_count;
  logic          write_fire;
  logic          last_write;

  loopback_fifo #(
    .DEPTH  (FIFO_DEPTH),
    .T_DATA (t_buffer_data)
  ) u_fifo (
    .clk       (clk),
    .reset     (reset),
    .enq_en    (fifo_enq_en),
    .enq_data  (fifo_enq_data),
    .not_full  (fifo_not_full),
    .deq_en    (fifo_deq_en),
    .deq_data  (fifo_deq_data),
    .not_empty (fifo_not_empty),
    .counter   (fifo_counter)
  );

  assign busy       = (state != S_IDLE);
  assign read_hold  = (fifo_counter >= HOLD_LEVEL);
  assign write_fire = out_valid && !write_full;
  assign last_write = write_fire && (wr_count == req_q.length - t_request_size'(1));

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= S_IDLE;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_REQUEST;
          end
        end
        S_REQUEST: state <= S_STREAM; // read command goes out in this cycle.
        S_STREAM: begin
          if (last_write) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == S_IDLE && start) begin
      req_q <= copy_req; // starts while busy are dropped here.
    end
  end

  always_comb begin
    read_cmd.strobe = (state == S_REQUEST);
    read_cmd.id     = req_q.src;
    read_cmd.length = req_q.length;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fifo_enq_en <= 1'b0;
    end else begin
      fifo_enq_en <= read_rsp.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (read_rsp.valid) begin
      fifo_enq_data <= read_rsp.data;
    end
  end

  // the output register refills in the same cycle that it empties.
  assign fifo_deq_en = fifo_not_empty && (!out_valid || write_fire);

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      out_valid <= 1'b0;
    end else if (fifo_deq_en) begin
      out_valid <= 1'b1;
    end else if (write_fire) begin
      out_valid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (fifo_deq_en) begin
      out_data <= fifo_deq_data;
    end
  end

  always_comb begin
    write_req.valid = write_fire;
    write_req.id    = req_q.dst;
    write_req.addr  = t_line_addr'(wr_count);
    write_req.data  = out_data;
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      wr_count <= '0;
      finish   <= 1'b0;
    end else begin
      finish <= last_write; // busy drops at the same edge.
      if (state == S_IDLE) begin
        wr_count <= '0;
      end else if (write_fire) begin
        wr_count <= wr_count + t_request_size'(1);
      end
    end
  end

endmodule : loopback

//--- verilog/hc_buffer_bank.sv
// buffer memories with host load/read port, read-stream sequencer and stallable write port.
`timescale 1ns/1ps

module hc_buffer_bank #(
  parameter int BUFFER_LINES = 64
) (
  input  logic               clk,
  input  logic               reset,
  input  hc_pkg::t_host_req  host_req,
  output hc_pkg::t_host_rsp  host_rsp,
  input  hc_pkg::t_read_cmd  read_cmd,
  input  logic               read_hold,
  output hc_pkg::t_read_rsp  read_rsp,
  input  hc_pkg::t_write_req write_req,
  output logic               write_full,
  input  logic               write_stall
);
  import hc_pkg::*;

  t_buffer_data            mem [NUM_BUFFERS][BUFFER_LINES];
  logic [BUFFER_LINES-1:0] written [NUM_BUFFERS];
  logic                    rd_active;
  t_buffer_id              rd_id;
  t_line_addr              rd_addr;
  t_request_size           rd_left;
  logic                    rd_issue;
  logic                    rsp_valid;
  t_buffer_data            rsp_data;
  logic                    host_valid;
  t_buffer_data            host_data;
  logic                    wr_en;
  t_buffer_id              wr_id;
  t_line_addr              wr_addr;
  t_buffer_data            wr_data;

  // lines never written since reset read back as zero.
  function automatic t_buffer_data line_at(input t_buffer_id id, input t_line_addr addr);
    return written[id][addr] ? mem[id][addr] : '0;
  endfunction

  // the host only touches the bank while the engine is idle.
  always_comb begin
    wr_en   = 1'b0;
    wr_id   = host_req.id;
    wr_addr = host_req.addr;
    wr_data = host_req.data;
    if (write_req.valid && !write_full) begin
      wr_en   = 1'b1;
      wr_id   = write_req.id;
      wr_addr = write_req.addr;
      wr_data = write_req.data;
    end else if (host_req.valid && host_req.write) begin
      wr_en = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_id][wr_addr] <= wr_data;
    end
  end

  assign rd_issue = rd_active && !read_hold;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      written[0] <= '0;
      written[1] <= '0;
      rd_active  <= 1'b0;
      rd_id      <= '0;
      rd_addr    <= '0;
      rd_left    <= '0;
      rsp_valid  <= 1'b0;
      host_valid <= 1'b0;
      write_full <= 1'b0;
    end else begin
      if (wr_en) begin
        written[wr_id][wr_addr] <= 1'b1;
      end
      rsp_valid  <= rd_issue;
      host_valid <= host_req.valid && !host_req.write;
      write_full <= write_stall;
      if (read_cmd.strobe) begin
        rd_active <= (read_cmd.length != '0);
        rd_id     <= read_cmd.id;
        rd_addr   <= '0; // streams always start at line zero.
        rd_left   <= read_cmd.length;
      end else if (rd_issue) begin
        rd_active <= (rd_left != t_request_size'(1));
        rd_addr   <= rd_addr + 1'b1;
        rd_left   <= rd_left - t_request_size'(1);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rd_issue) begin
      rsp_data <= line_at(rd_id, rd_addr);
    end
    if (host_req.valid && !host_req.write) begin
      host_data <= line_at(host_req.id, host_req.addr);
    end
  end

  assign read_rsp = '{valid: rsp_valid, data: rsp_data};
  assign host_rsp = '{valid: host_valid, data: host_data};

endmodule : hc_buffer_bank

//--- verilog/hc_loopback_top.sv
// top level joining the buffer bank and the loopback copy engine.
`timescale 1ns/1ps

module hc_loopback_top #(
  parameter int FIFO_DEPTH   = 8,
  parameter int BUFFER_LINES = 64
) (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  hc_pkg::t_copy_req copy_req,
  output logic              busy,
  output logic              finish,
  input  logic              write_stall,
  input  hc_pkg::t_host_req host_req,
  output hc_pkg::t_host_rsp host_rsp
);
  import hc_pkg::*;

  t_read_cmd  read_cmd;
  logic       read_hold;
  t_read_rsp  read_rsp;
  t_write_req write_req;
  logic       write_full;

  loopback #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_loopback (
    .clk        (clk),
    .reset      (reset),
    .start      (start),
    .copy_req   (copy_req),
    .busy       (busy),
    .finish     (finish),
    .read_cmd   (read_cmd),
    .read_hold  (read_hold),
    .read_rsp   (read_rsp),
    .write_req  (write_req),
    .write_full (write_full)
  );

  hc_buffer_bank #(
    .BUFFER_LINES (BUFFER_LINES)
  ) u_bank (
    .clk         (clk),
    .reset       (reset),
    .host_req    (host_req),
    .host_rsp    (host_rsp),
    .read_cmd    (read_cmd),
    .read_hold   (read_hold),
    .read_rsp    (read_rsp),
    .write_req   (write_req),
    .write_full  (write_full),
    .write_stall (write_stall)
  );

endmodule : hc_loopback_top

//--- dv/hc_loopback_assert.sv
// concurrent checks on the engine FIFO flags, the finish pulse and the write strobe.
`timescale 1ns/1ps

module hc_loopback_assert (
  input logic               clk,
  input logic               reset,
  input logic               fifo_enq_en,
  input logic               fifo_not_full,
  input logic               finish,
  input logic               write_full,
  input logic               out_valid,
  input hc_pkg::t_write_req write_req
);
  import hc_pkg::*;

  // read_hold must keep the FIFO from ever seeing a push when it is full.
  no_overflow: assert property (@(posedge clk) disable iff (reset)
    fifo_enq_en |-> fifo_not_full)
    else $error("FIFO enqueue while full");

  finish_pulse: assert property (@(posedge clk) disable iff (reset)
    finish |=> !finish)
    else $error("finish held high for more than one cycle");

  // a line held back by write_full stays in the output register unchanged.
  write_held: assert property (@(posedge clk) disable iff (reset)
    (out_valid && write_full) |=> out_valid && $stable(write_req.addr)
                                  && $stable(write_req.data))
    else $error("held line changed while write_full is high");

endmodule : hc_loopback_assert

bind loopback hc_loopback_assert u_assert (
  .clk            (clk),
  .reset          (reset),
  .fifo_enq_en    (fifo_enq_en),
  .fifo_not_full  (fifo_not_full),
  .finish         (finish),
  .write_full     (write_full),
  .out_valid      (out_valid),
  .write_req      (write_req)
);

//--- dv/hc_loopback_tb.sv
// testbench for the buffer copy engine with stimulus table, host access tasks and compare tasks.
`timescale 1ns/1ps

module hc_loopback_tb;
  import hc_pkg::*;

  localparam int FIFO_DEPTH   = 8;
  localparam int BUFFER_LINES = 64;
  localparam int TIMEOUT      = 2000;
  localparam int TAIL_CYCLES  = 2 * FIFO_DEPTH;
  localparam int NUM_ROWS     = 6;

  typedef enum logic [1:0] {
    STALL_NONE,
    STALL_RANDOM,
    STALL_BURST
  } t_stall;

  typedef struct packed {
    t_buffer_id    src;
    t_buffer_id    dst;
    t_request_size length;
    t_stall        stall;
    logic          restart;  // a second start arrives while busy.
    t_request_size finishes; // finish pulses expected per copy.
  } t_row;

  localparam t_row ROWS [NUM_ROWS] = '{
    '{src: 1'b0, dst: 1'b1, length: 7'd1,  stall: STALL_NONE,   restart: 1'b0, finishes: 7'd1},
    '{src: 1'b0, dst: 1'b1, length: 7'd64, stall: STALL_NONE,   restart: 1'b0, finishes: 7'd1},
    '{src: 1'b0, dst: 1'b1, length: 7'd40, stall: STALL_RANDOM, restart: 1'b0, finishes: 7'd1},
    '{src: 1'b0, dst: 1'b1, length: 7'd64, stall: STALL_BURST,  restart: 1'b0, finishes: 7'd1},
    '{src: 1'b0, dst: 1'b1, length: 7'd30, stall: STALL_NONE,   restart: 1'b1, finishes: 7'd1},
    '{src: 1'b1, dst: 1'b0, length: 7'd20, stall: STALL_RANDOM, restart: 1'b0, finishes: 7'd1}
  };

  logic         clk = 1'b0;
  logic         reset;
  logic         start;
  t_copy_req    copy_req;
  logic         busy;
  logic         finish;
  logic         write_stall;
  t_host_req    host_req;
  t_host_rsp    host_rsp;
  t_buffer_data model [NUM_BUFFERS][BUFFER_LINES]; // expected contents of both buffers.
  t_buffer_data rd_line;

  hc_loopback_top #(
    .FIFO_DEPTH   (FIFO_DEPTH),
    .BUFFER_LINES (BUFFER_LINES)
  ) uut (
    .clk         (clk),
    .reset       (reset),
    .start       (start),
    .copy_req    (copy_req),
    .busy        (busy),
    .finish      (finish),
    .write_stall (write_stall),
    .host_req    (host_req),
    .host_rsp    (host_rsp)
  );

  always #4 clk = ~clk;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("FAIL: see errors above");
    $fatal(1);
  endtask

  task automatic check_line(input string name, input t_buffer_data actual,
                            input t_buffer_data expected);
    if (actual !== expected) begin
      $display("Fail at %0t: %s = %h, expected %h", $time, name, actual, expected);
      stop_with_failure("a buffer line does not match");
    end
  endtask

  task automatic check_flag(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("Fail at %0t: %s = %b, expected %b", $time, name, actual, expected);
      stop_with_failure("a control flag has the wrong level");
    end
  endtask

  task automatic check_count(input string name, input t_request_size actual,
                             input t_request_size expected);
    if (actual !== expected) begin
      $display("Fail at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
      stop_with_failure("a pulse count is wrong");
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1; // inputs change just after the edge.
  endtask

  function automatic logic stall_level(input t_stall mode, input int cycle);
    case (mode)
      STALL_RANDOM: return ($urandom_range(1, 0) == 1);
      STALL_BURST:  return (cycle >= 6) && (cycle < 6 + 3 * FIFO_DEPTH);
      default:      return 1'b0;
    endcase
  endfunction

  task automatic host_read(input t_buffer_id id, input t_line_addr addr,
                           output t_buffer_data data);
    int waited;
    host_req = '{valid: 1'b1, write: 1'b0, id: id, addr: addr, data: '0};
    next_cycle();
    host_req.valid = 1'b0;
    waited = 0;
    while (!host_rsp.valid) begin
      if (waited == TIMEOUT) begin
        stop_with_failure("timeout while waiting for a host read response");
      end
      next_cycle();
      waited++;
    end
    data = host_rsp.data;
  endtask

  task automatic run_copy(input t_row row);
    int            waited;
    t_request_size finishes;
    t_buffer_data  line;
    for (int a = 0; a < BUFFER_LINES; a++) begin
      model[row.src][a] = {$urandom, $urandom};
      host_req = '{valid: 1'b1, write: 1'b1, id: row.src, addr: t_line_addr'(a),
                   data: model[row.src][a]};
      next_cycle();
    end
    host_req.valid = 1'b0;
    copy_req = '{src: row.src, dst: row.dst, length: row.length};
    start = 1'b1;
    next_cycle();
    start = 1'b0;
    check_flag("busy", busy, 1'b1);
    if (row.restart) begin
      copy_req = '{src: row.dst, dst: row.src, length: 7'd3}; // must be dropped while busy.
      start = 1'b1;
      next_cycle();
      start = 1'b0;
    end
    waited = 0;
    while (!finish) begin
      if (waited == TIMEOUT) begin
        stop_with_failure("timeout while waiting for finish");
      end
      write_stall = stall_level(row.stall, waited);
      next_cycle();
      waited++;
    end
    write_stall = 1'b0;
    check_flag("busy", busy, 1'b0); // busy falls together with finish.
    finishes = '0;
    for (int c = 0; c < TAIL_CYCLES; c++) begin
      if (finish) begin
        finishes++;
      end
      next_cycle();
    end
    check_count("finish pulses", finishes, row.finishes);
    for (int a = 0; a < BUFFER_LINES; a++) begin
      if (t_request_size'(a) < row.length) begin
        model[row.dst][a] = model[row.src][a];
      end
    end
    for (int a = 0; a < BUFFER_LINES; a++) begin
      host_read(row.dst, t_line_addr'(a), line);
      check_line($sformatf("buffer %0d line %0d", row.dst, a), line, model[row.dst][a]);
    end
  endtask

  initial begin
    void'($urandom(32'h53ee_159e));
    reset       = 1'b1;
    start       = 1'b0;
    copy_req    = '0;
    write_stall = 1'b0;
    host_req    = '0;
    for (int b = 0; b < NUM_BUFFERS; b++) begin
      for (int a = 0; a < BUFFER_LINES; a++) begin
        model[b][a] = '0; // unwritten lines read back as zero.
      end
    end
    repeat (5) next_cycle();
    reset = 1'b0;
    next_cycle();
    check_flag("busy", busy, 1'b0);
    check_flag("finish", finish, 1'b0);
    check_flag("host_rsp.valid", host_rsp.valid, 1'b0);
    for (int a = 0; a < BUFFER_LINES; a += 9) begin
      host_read(1'b0, t_line_addr'(a), rd_line);
      check_line($sformatf("buffer 0 line %0d", a), rd_line, model[0][a]);
      host_read(1'b1, t_line_addr'(a), rd_line);
      check_line($sformatf("buffer 1 line %0d", a), rd_line, model[1][a]);
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      run_copy(ROWS[r]);
    end
    $display("PASS: all tests");
    $finish;
  end

endmodule : hc_loopback_tb

//--- tb.f
verilog/hc_pkg.sv
verilog/loopback_fifo.sv
verilog/loopback.sv
verilog/hc_buffer_bank.sv
verilog/hc_loopback_top.sv
dv/hc_loopback_assert.sv
dv/hc_loopback_tb.sv

//--- Makefile
# Verilator build and run for the buffer copy engine testbench.

VERILATOR ?= verilator
TOP       ?= hc_loopback_tb
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --Wno-fatal
FAIL_MSG  := FAIL: see errors above
PASS_MSG  := PASS: all tests

SOURCES := $(wildcard verilog/*.sv dv/*.sv)
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BINARY) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qF "$(FAIL_MSG)" $(LOG); then echo "simulation failed"; exit 1; fi
	@if ! grep -qF "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
